/* design/adc_capture_pkg.sv */
/*
 * ADC capture package
 * Sizes, the converter test pattern and the types shared by the
 * serial ADC capture path.
 */

package adc_capture_pkg;

  // ************************************************************
  // Converter and capture sizes
  // ************************************************************

  // Bits in one conversion result
  localparam int sample_width = 20;

  // Cycles from the sampled cnv pulse to the first sampled data bit
  localparam int capture_delay = 4;

  // Words held by the output FIFO
  localparam int fifo_depth = 4;

  // Counter wide enough for the longest bit window
  localparam int count_width = $clog2(sample_width);

  // FIFO pointer and fill level widths
  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int fill_width = $clog2(fifo_depth + 1);

  // ************************************************************
  // Types
  // ************************************************************

  typedef logic [sample_width-1:0] sample_t;
  typedef logic [count_width-1:0] count_t;
  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [fill_width-1:0] fill_t;

  // Word the converter sends while its test pattern mode is on
  localparam sample_t test_pattern = 20'hac5d6;

  // Single lane needs 20 shift cycles and dual lane needs 10
  typedef enum logic {
    lane_single = 1'b0,
    lane_dual   = 1'b1
  } lane_mode_e;

  // One captured conversion with its pattern mode tag
  typedef struct packed {
    sample_t data;
    logic    pattern;
  } adc_word_s;

  // Sticky status flags, cleared only by reset
  typedef struct packed {
    logic pattern_err;
    logic overrun;
    logic cnv_miss;
  } capture_status_s;

endpackage

/* design/adc_capture_top.sv */
/*
 * Serial ADC capture top level
 * Conversion timing, lane deserializing, test pattern checking and
 * output buffering for a 20-bit converter with one or two data lanes.
 */

`timescale 1ns/1ps

module adc_capture_top
  import adc_capture_pkg::*;
(
  input  logic            ssi_clk,
  input  logic            rst_n,
  input  logic            cnv,
  input  logic            da,
  input  logic            db,
  input  lane_mode_e      lane_mode,
  input  logic            pattern_en,
  input  logic            out_ready,
  output logic            out_valid,
  output adc_word_s       out_word,
  output capture_status_s status,
  output logic            busy
);

  logic      shift_en;
  logic      frame_done;
  logic      cnv_miss;
  logic      pattern_err;
  logic      overrun;
  adc_word_s word;
  logic      word_valid;

  // ************************************************************
  // Conversion timing
  // ************************************************************

  cnv_timer u_cnv_timer (
    .ssi_clk    (ssi_clk),
    .rst_n      (rst_n),
    .cnv        (cnv),
    .lane_mode  (lane_mode),
    .shift_en   (shift_en),
    .frame_done (frame_done),
    .busy       (busy),
    .cnv_miss   (cnv_miss)
  );

  // Lane bits become a word in the frame_done cycle
  lane_deserializer u_lane_deserializer (
    .ssi_clk    (ssi_clk),
    .rst_n      (rst_n),
    .da         (da),
    .db         (db),
    .shift_en   (shift_en),
    .frame_done (frame_done),
    .lane_mode  (lane_mode),
    .pattern_en (pattern_en),
    .word       (word),
    .word_valid (word_valid)
  );

  pattern_checker u_pattern_checker (
    .ssi_clk     (ssi_clk),
    .rst_n       (rst_n),
    .word        (word),
    .word_valid  (word_valid),
    .pattern_err (pattern_err)
  );

  // ************************************************************
  // Output buffering
  // ************************************************************

  sample_fifo u_sample_fifo (
    .ssi_clk   (ssi_clk),
    .rst_n     (rst_n),
    .in_valid  (word_valid),
    .in_word   (word),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_ready (out_ready),
    .overrun   (overrun)
  );

  // Sticky flags gathered into one status word
  assign status.pattern_err = pattern_err;
  assign status.overrun     = overrun;
  assign status.cnv_miss    = cnv_miss;

endmodule

/* design/cnv_timer.sv */
/*
 * Conversion window sequencer
 * Turns a cnv start pulse into the bit sampling window after the fixed
 * converter latency, then strobes frame_done once the window closes.
 */

`timescale 1ns/1ps

module cnv_timer
  import adc_capture_pkg::*;
(
  input  logic       ssi_clk,
  input  logic       rst_n,
  input  logic       cnv,
  input  lane_mode_e lane_mode,
  output logic       shift_en,
  output logic       frame_done,
  output logic       busy,
  output logic       cnv_miss
);

  typedef enum logic [1:0] {
    st_idle,
    st_delay,
    st_shift
  } timer_state_e;

  timer_state_e state_q;
  count_t       cnt_q;
  count_t       last_shift;
  logic         frame_done_q;
  logic         cnv_miss_q;

  // Index of the final bit cycle, dual lane halves the window
  assign last_shift = (lane_mode == lane_dual) ? count_t'(sample_width / 2 - 1)
                                               : count_t'(sample_width - 1);

  // ************************************************************
  // Window FSM
  // ************************************************************

  // The delay state lasts capture_delay-1 cycles so that the first
  // shift lands exactly capture_delay edges after cnv was sampled
  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      state_q      <= st_idle;
      cnt_q        <= '0;
      frame_done_q <= 1'b0;
      cnv_miss_q   <= 1'b0;
    end else begin
      frame_done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (cnv) begin
            state_q <= st_delay;
            cnt_q   <= '0;
          end
        end
        st_delay: begin
          if (cnt_q == count_t'(capture_delay - 2)) begin
            state_q <= st_shift;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        st_shift: begin
          if (cnt_q == last_shift) begin
            state_q      <= st_idle;
            cnt_q        <= '0;
            frame_done_q <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
      // A start pulse during an open window is dropped but remembered
      if (cnv && (state_q != st_idle)) begin
        cnv_miss_q <= 1'b1;
      end
    end
  end

  assign shift_en   = (state_q == st_shift);
  assign frame_done = frame_done_q;
  assign cnv_miss   = cnv_miss_q;

  // Busy also covers the frame_done cycle while the word is handed on
  assign busy = (state_q != st_idle) || frame_done_q;

  // ************************************************************
  // Assertions
  // ************************************************************

  // The bit window opens exactly capture_delay edges after an accepted cnv
  shift_latency_a: assert property (@(posedge ssi_clk) disable iff (!rst_n)
    $rose(shift_en) |-> $past(cnv && (state_q == st_idle), capture_delay));

  done_pulse_a: assert property (@(posedge ssi_clk) disable iff (!rst_n)
    frame_done |=> !frame_done);

endmodule

/* design/lane_deserializer.sv */
/*
 * Lane deserializer
 * Collects one or two lane bits per shift cycle, MSB first, and presents
 * the finished 20-bit word with its pattern tag on frame end.
 */

`timescale 1ns/1ps

module lane_deserializer
  import adc_capture_pkg::*;
(
  input  logic       ssi_clk,
  input  logic       rst_n,
  input  logic       da,
  input  logic       db,
  input  logic       shift_en,
  input  logic       frame_done,
  input  lane_mode_e lane_mode,
  input  logic       pattern_en,
  output adc_word_s  word,
  output logic       word_valid
);

  sample_t shift_q;
  count_t  shifts_q;
  count_t  expected_shifts;

  // Shift register holds the result, the last shift completes it
  // one cycle before frame_done so no extra stage is needed
  always_ff @(posedge ssi_clk) begin
    if (shift_en) begin
      if (lane_mode == lane_dual) begin
        // da carries the higher bit of each pair
        shift_q <= {shift_q[sample_width-3:0], da, db};
      end else begin
        shift_q <= {shift_q[sample_width-2:0], da};
      end
    end
  end

  // Shift cycles seen in the current frame
  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      shifts_q <= '0;
    end else if (frame_done) begin
      shifts_q <= '0;
    end else if (shift_en) begin
      shifts_q <= shifts_q + 1'b1;
    end
  end

  assign expected_shifts = (lane_mode == lane_dual) ? count_t'(sample_width / 2)
                                                    : count_t'(sample_width);

  assign word.data    = shift_q;
  assign word.pattern = pattern_en;
  assign word_valid   = frame_done;

  // The timer window must match the bit count the lane mode needs
  frame_len_a: assert property (@(posedge ssi_clk) disable iff (!rst_n)
    frame_done |-> (shifts_q == expected_shifts));

endmodule

/* design/pattern_checker.sv */
/*
 * Test pattern checker
 * Compares words captured in pattern mode against the converter's fixed
 * pattern and holds a sticky mismatch flag.
 */

`timescale 1ns/1ps

module pattern_checker
  import adc_capture_pkg::*;
(
  input  logic      ssi_clk,
  input  logic      rst_n,
  input  adc_word_s word,
  input  logic      word_valid,
  output logic      pattern_err
);

  logic check_hit;
  logic mismatch;
  logic pattern_err_q;

  // Only words tagged as pattern captures are compared
  assign check_hit = word_valid && word.pattern;
  assign mismatch  = (word.data != test_pattern);

  // ************************************************************
  // Sticky error flag
  // ************************************************************

  // Set one cycle after the bad word, cleared only by reset
  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      pattern_err_q <= 1'b0;
    end else if (check_hit && mismatch) begin
      pattern_err_q <= 1'b1;
    end
  end

  assign pattern_err = pattern_err_q;

endmodule

/* design/sample_fifo.sv */
/*
 * Sample FIFO
 * Small circular buffer of captured words with a valid/ready output.
 * The input cannot stall, so a push into a full buffer is dropped.
 */

`timescale 1ns/1ps

module sample_fifo
  import adc_capture_pkg::*;
(
  input  logic      ssi_clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  adc_word_s in_word,
  output logic      out_valid,
  output adc_word_s out_word,
  input  logic      out_ready,
  output logic      overrun
);

  adc_word_s mem [fifo_depth];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  fill_t     count_q;
  logic      overrun_q;
  logic      full;
  logic      push;
  logic      pop;

  assign full = (count_q == fill_t'(fifo_depth));
  assign pop  = out_valid && out_ready;

  // A full buffer still accepts a word when the head leaves this cycle
  assign push = in_valid && (!full || pop);

  // ************************************************************
  // Storage
  // ************************************************************

  always_ff @(posedge ssi_clk) begin
    if (push) begin
      mem[wr_ptr_q] <= in_word;
    end
  end

  // ************************************************************
  // Pointers, fill level and overrun
  // ************************************************************

  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      overrun_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // Dropped word, the stored ones stay in order
      if (in_valid && !push) begin
        overrun_q <= 1'b1;
      end
    end
  end

  // Head of the buffer is shown as soon as it is written
  assign out_valid = (count_q != '0);
  assign out_word  = mem[rd_ptr_q];
  assign overrun   = overrun_q;

  // ************************************************************
  // Assertions
  // ************************************************************

  fill_bound_a: assert property (@(posedge ssi_clk) disable iff (!rst_n)
    count_q <= fill_t'(fifo_depth));

  // A stalled word must hold until the consumer takes it
  hold_stable_a: assert property (@(posedge ssi_clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_word)));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ADC capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module adc_capture_tb \
  -f sources.f --Mdir obj_dir -o adc_capture_sim

result=$(./obj_dir/adc_capture_sim 2>&1) || true
echo "$result"
echo "$result" | grep -qx "test passed"

/* sources.f */
design/adc_capture_pkg.sv
design/cnv_timer.sv
design/lane_deserializer.sv
design/pattern_checker.sv
design/sample_fifo.sv
design/adc_capture_top.sv
verification/adc_capture_tb.sv

/* verification/adc_capture_tb.sv */
/*
 * Serial ADC capture testbench
 * Reads frames from the stim file, serializes each sample onto the lanes,
 * and checks the words leaving the FIFO and the sticky status flags.
 */

`timescale 1ns/1ps

module adc_capture_tb;
  import adc_capture_pkg::*;

  localparam int clk_period = 8;
  localparam int reset_cycles = 16;
  localparam int wait_limit = 200;
  localparam logic [31:0] lcg_seed = 32'd52768;

  logic            ssi_clk;
  logic            rst_n;
  logic            cnv;
  logic            da;
  logic            db;
  lane_mode_e      lane_mode;
  logic            pattern_en;
  logic            out_ready;
  logic            out_valid;
  adc_word_s       out_word;
  capture_status_s status;
  logic            busy;

  // Words still due at the output, oldest first
  adc_word_s   expect_q[$];
  // Cycle count of the consumer and the end of the current ready hold-off
  int          cyc = 0;
  int          hold_end = 0;
  logic [31:0] rng_state;

  adc_capture_top dut (
    .ssi_clk    (ssi_clk),
    .rst_n      (rst_n),
    .cnv        (cnv),
    .da         (da),
    .db         (db),
    .lane_mode  (lane_mode),
    .pattern_en (pattern_en),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .status     (status),
    .busy       (busy)
  );

  initial begin
    ssi_clk = 1'b0;
    forever #(clk_period / 2) ssi_clk = ~ssi_clk;
  end

  // ************************************************************
  // Reporting and compare helpers
  // ************************************************************

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input adc_word_s got, input adc_word_s exp);
    if (got !== exp) begin
      $display("error out_word got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input capture_status_s got, input capture_status_s exp);
    if (got !== exp) begin
      $display("error status got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ************************************************************
  // Wait loops, each bounded by its own timeout
  // ************************************************************

  // Sampled just after the edge, where busy has settled
  task automatic wait_not_busy();
    int n;
    n = 0;
    @(posedge ssi_clk);
    #1;
    while (busy) begin
      if (n == wait_limit) begin
        $display("timeout, busy stayed high after a frame");
        abort_run();
      end
      n++;
      @(posedge ssi_clk);
      #1;
    end
  endtask

  // Queue and hold state are checked on the edge, away from the consumer's updates
  task automatic wait_drained();
    int n;
    n = 0;
    @(posedge ssi_clk);
    while (expect_q.size() != 0) begin
      if (n == wait_limit) begin
        $display("timeout, expected words never left the FIFO");
        abort_run();
      end
      n++;
      @(posedge ssi_clk);
    end
  endtask

  task automatic wait_hold_over();
    int n;
    n = 0;
    while (cyc < hold_end) begin
      if (n == wait_limit) begin
        $display("timeout, the out_ready hold-off never ended");
        abort_run();
      end
      n++;
      @(posedge ssi_clk);
    end
  endtask

  // ************************************************************
  // Frame driver
  // ************************************************************

  // Pulses cnv, then shifts the sample out MSB first so that the first bit
  // is on the lanes at the edge capture_delay cycles after cnv is sampled
  task automatic run_frame(input lane_mode_e mode, input logic pat, input sample_t smp,
                           input int hold, input logic miss, input logic keep);
    int        nbits;
    sample_t   bits;
    adc_word_s w;
    nbits = (mode == lane_dual) ? sample_width / 2 : sample_width;
    bits = smp;
    @(posedge ssi_clk);
    // A new hold-off starts from an empty FIFO, a plain frame waits for it to end
    if (hold > 0 && cyc >= hold_end) begin
      wait_drained();
    end
    if (hold == 0) begin
      wait_hold_over();
    end else begin
      hold_end = cyc + hold;
    end
    if (keep) begin
      w.data = smp;
      w.pattern = pat;
      expect_q.push_back(w);
    end
    #1;
    lane_mode = mode;
    pattern_en = pat;
    cnv = 1'b1;
    @(posedge ssi_clk);
    #1;
    cnv = 1'b0;
    // The window opens on the edge that took cnv
    check_flag("busy", busy, 1'b1);
    repeat (capture_delay - 1) @(posedge ssi_clk);
    for (int k = 0; k < nbits; k++) begin
      if (k > 0) begin
        @(posedge ssi_clk);
      end
      #1;
      // Optional stray start pulse inside the open window
      cnv = miss && (k == 2);
      da = bits[sample_width-1];
      if (mode == lane_dual) begin
        db = bits[sample_width-2];
        bits = bits << 2;
      end else begin
        db = 1'b0;
        bits = bits << 1;
      end
    end
    @(posedge ssi_clk);
    #1;
    da = 1'b0;
    db = 1'b0;
    // Busy still covers the frame_done cycle
    check_flag("busy", busy, 1'b1);
    wait_not_busy();
  endtask

  // ************************************************************
  // Output consumer with random ready gaps
  // ************************************************************

  initial begin
    logic      take;
    adc_word_s want;
    int        n;
    out_ready = 1'b0;
    rng_state = lcg_seed;
    n = 0;
    // Hold off until the main sequence releases reset
    while (rst_n !== 1'b1) begin
      if (n == wait_limit) begin
        $display("timeout, reset was never released");
        abort_run();
      end
      n++;
      @(posedge ssi_clk);
    end
    forever begin
      @(posedge ssi_clk);
      #1;
      cyc++;
      rng_state = lcg_next(rng_state);
      // Ready about three cycles in four, forced low during a hold-off
      take = (cyc >= hold_end) && (rng_state[17:16] != 2'b00);
      out_ready = take;
      if (take && out_valid) begin
        if (expect_q.size() == 0) begin
          $display("a word left the FIFO that no frame should have produced");
          abort_run();
        end
        want = expect_q.pop_front();
        check_word(out_word, want);
      end
    end
  end

  // ************************************************************
  // Main sequence
  // ************************************************************

  initial begin
    int              fd;
    int              n;
    string           line;
    logic [31:0]     f_mode;
    logic [31:0]     f_pat;
    logic [31:0]     f_smp;
    int              f_hold;
    logic [31:0]     f_miss;
    logic [31:0]     f_keep;
    logic [31:0]     f_stat;
    capture_status_s want_status;
    rst_n = 1'b0;
    cnv = 1'b0;
    da = 1'b0;
    db = 1'b0;
    lane_mode = lane_single;
    pattern_en = 1'b0;
    want_status = '0;
    repeat (reset_cycles) @(posedge ssi_clk);
    #1;
    rst_n = 1'b1;
    @(posedge ssi_clk);
    #1;
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_status(status, want_status);

    fd = $fopen("verification/adc_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stim file");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %d %h %h %h", f_mode, f_pat, f_smp, f_hold, f_miss,
                  f_keep, f_stat);
      if (n != 7) begin
        $display("malformed stim line %s", line);
        abort_run();
      end
      want_status = capture_status_s'(f_stat[2:0]);
      run_frame(lane_mode_e'(f_mode[0]), f_pat[0], f_smp[sample_width-1:0], f_hold,
                f_miss[0], f_keep[0]);
      check_status(status, want_status);
    end
    $fclose(fd);

    // Every kept word must come out and nothing may follow
    wait_drained();
    repeat (20) begin
      @(posedge ssi_clk);
      #1;
      check_flag("out_valid", out_valid, 1'b0);
    end
    check_status(status, want_status);
    $display("test passed");
    $finish;
  end

endmodule

/* verification/adc_stim.txt */
# mode pattern sample hold miss keep status (all hex except hold in decimal cycles)
# mode 0 single 1 dual, miss adds a second cnv, status bits are pattern_err overrun cnv_miss
0 0 12345 0 0 1 0
0 0 fedcb 0 0 1 0
0 0 80001 0 0 1 0
0 0 5a5a5 0 0 1 0
1 0 3c3c3 0 0 1 0
1 0 ffff0 0 0 1 0
1 0 00001 0 0 1 0
1 0 96e1d 0 0 1 0
0 1 ac5d6 0 0 1 0
1 1 ac5d6 0 0 1 0
0 1 ac5d7 0 0 1 4
1 1 ac5d6 0 0 1 4
0 0 ac5d7 0 0 1 4
0 0 11111 60 0 1 4
0 0 22222 60 0 1 4
0 0 33333 60 0 1 4
1 0 44444 60 0 1 4
0 0 55555 60 0 0 6
1 0 66666 60 0 0 6
0 0 77777 0 1 1 7
1 0 0abcd 0 0 1 7
